// ==== common/traffic_params.svh ====
`ifndef TRAFFIC_PARAMS_SVH
`define TRAFFIC_PARAMS_SVH

// ----------------------------------------------------------------------
// raster timing for 640x480 at a 25 MHz pixel clock
// ----------------------------------------------------------------------
`define H_TOTAL 10'd800
`define V_TOTAL 10'd521
// sync pulse widths in clocks and lines
`define H_PULSE 10'd96
`define V_PULSE 10'd2
// active window edges
`define H_BP 10'd144
`define H_FP 10'd784
`define V_BP 10'd31
`define V_FP 10'd511
`define SCR_W 10'd640
`define SCR_H 10'd480

// ----------------------------------------------------------------------
// game geometry
// ----------------------------------------------------------------------
// car length along travel and width across it
`define CAR_LEN 10'd60
`define CAR_WID 10'd30
// offsets where a car waits on red
`define STOP_V 10'd60
`define STOP_H 10'd140
// offsets that count as a crossing
`define CROSS_V 10'd360
`define CROSS_H 10'd440
`define WIN_SCORE 10'd20

// colours as rrrgggbb
`define COL_BLACK 8'b000_000_00
`define COL_WHITE 8'b111_111_11
`define COL_YELLOW 8'b111_111_00
`define COL_CYAN 8'b000_111_11
`define COL_GREEN 8'b000_111_00
`define COL_MAGENTA 8'b111_000_11
`define COL_RED 8'b111_000_00
`define COL_BLUE 8'b000_000_11

`endif

// ==== common/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

	// counter values and pixel coordinates
	typedef logic [9:0] coord_t;

	// true when (x,y) falls in the w by h box at (x0,y0)
	// upper edges kept 11 bits wide so a box past 1023 never wraps back
	function automatic logic in_rect(coord_t x, coord_t y, coord_t x0, coord_t y0,
		coord_t w, coord_t h);
		logic [10:0] x1;
		logic [10:0] y1;
		begin
			x1 = {1'b0, x0} + {1'b0, w};
			y1 = {1'b0, y0} + {1'b0, h};
			in_rect = (x >= x0) && ({1'b0, x} < x1) && (y >= y0) && ({1'b0, y} < y1);
		end
	endfunction

endpackage

`default_nettype wire

// ==== common/traffic_pkg.sv ====
`default_nettype none

package traffic_pkg;

	// ------------------------------------------------------------------
	// pixel colour
	// ------------------------------------------------------------------
	// field view matching the vga pins
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_t;

	// same byte seen whole or split into channels
	typedef union packed {
		logic [7:0] word;
		rgb_t       rgb;
	} color_t;

	// ------------------------------------------------------------------
	// car travel
	// ------------------------------------------------------------------
	// direction of travel, matching the light bit order
	typedef enum logic [1:0] {
		north = 2'd0,
		east  = 2'd1,
		south = 2'd2,
		west  = 2'd3
	} dir_t;

	// distance travelled, wraps at 1024
	typedef logic [9:0] offset_t;

endpackage

`default_nettype wire

// ==== video/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module vga_timing import vga_pkg::*; (
	input  logic   dclk,
	input  logic   clr,
	output coord_t hc,
	output coord_t vc,
	output coord_t px,
	output coord_t py,
	output logic   active,
	output logic   hsync_raw,
	output logic   vsync_raw
);

	// ------------------------------------------------------------------
	// line and frame counters
	// ------------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (hc == `H_TOTAL - 10'd1)
		begin
			// end of line
			hc <= '0;
			// last line wraps the frame
			if (vc == `V_TOTAL - 10'd1)
				vc <= '0;
			else
				vc <= vc + 10'd1;
		end
		else
			hc <= hc + 10'd1;
	end

	// visible window between the porches
	assign active = (hc >= `H_BP) && (hc < `H_FP) && (vc >= `V_BP) && (vc < `V_FP);

	// screen coordinates only meaningful while active
	assign px = hc - `H_BP;
	assign py = vc - `V_BP;

	// sync pulses active low at the start of line and frame
	assign hsync_raw = (hc >= `H_PULSE);
	assign vsync_raw = (vc >= `V_PULSE);

endmodule

`default_nettype wire

// ==== video/pixel_out.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module pixel_out import traffic_pkg::*; (
	input  logic       dclk,
	input  logic       clr,
	input  logic       active,
	input  logic       hsync_raw,
	input  logic       vsync_raw,
	input  logic       top_hit,
	input  color_t     top_color,
	input  logic       car_hit,
	input  color_t     car_color,
	input  color_t     bg_color,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue
);

	color_t sel;
	color_t pix_q;

	// layer priority
	// lamps and boxes over cars over the road scene
	always_comb
	begin
		if (!active)
			sel.word = `COL_BLACK;
		else if (top_hit)
			sel = top_color;
		else if (car_hit)
			sel = car_color;
		else
			sel = bg_color;
	end

	// colour and sync leave through the same register stage
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			pix_q.word <= `COL_BLACK;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			pix_q <= sel;
			hsync <= hsync_raw;
			vsync <= vsync_raw;
		end
	end

	// split into pins
	assign red = pix_q.rgb.r;
	assign green = pix_q.rgb.g;
	assign blue = pix_q.rgb.b;

endmodule

`default_nettype wire

// ==== scene/road_painter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module road_painter import vga_pkg::*, traffic_pkg::*; (
	input  coord_t     px,
	input  coord_t     py,
	input  logic [3:0] light,
	output logic       top_hit,
	output color_t     top_color,
	output color_t     bg_color
);

	// ------------------------------------------------------------------
	// lamp positions
	// ------------------------------------------------------------------
	// index is the light bit
	// north east south west
	localparam coord_t red_x [4] = '{10'd363, 10'd615, 10'd262, 10'd5};
	localparam coord_t red_y [4] = '{10'd5, 10'd283, 10'd460, 10'd182};
	localparam coord_t green_x [4] = '{10'd382, 10'd615, 10'd243, 10'd5};
	localparam coord_t green_y [4] = '{10'd5, 10'd302, 10'd460, 10'd163};
	// square lamps
	localparam coord_t lamp_sz = 10'd15;

	logic [3:0] red_at;
	logic [3:0] green_at;
	logic       box_at;
	logic       centre_at;
	logic       line_at;
	logic       road_at;

	// lamp hit tests
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			red_at[i] = in_rect(px, py, red_x[i], red_y[i], lamp_sz, lamp_sz);
			green_at[i] = in_rect(px, py, green_x[i], green_y[i], lamp_sz, lamp_sz);
		end
	end

	// yellow housings
	// upright ones on the side roads and flat ones above and below
	assign box_at = in_rect(px, py, 10'd0, 10'd160, 10'd25, 10'd40)
		|| in_rect(px, py, 10'd610, 10'd280, 10'd25, 10'd40)
		|| in_rect(px, py, 10'd360, 10'd0, 10'd40, 10'd25)
		|| in_rect(px, py, 10'd240, 10'd455, 10'd40, 10'd25);

	// ------------------------------------------------------------------
	// top layer
	// ------------------------------------------------------------------
	// lamps never overlap so one or-reduce picks the state
	always_comb
	begin
		top_hit = 1'b1;
		if (|red_at)
			top_color.word = |(red_at & light) ? `COL_BLACK : `COL_RED;
		else if (|green_at)
			top_color.word = |(green_at & light) ? `COL_GREEN : `COL_BLACK;
		else if (box_at)
			top_color.word = `COL_YELLOW;
		else
		begin
			top_hit = 1'b0;
			top_color.word = `COL_BLACK;
		end
	end

	// ------------------------------------------------------------------
	// background layer
	// ------------------------------------------------------------------
	assign centre_at = in_rect(px, py, 10'd200, 10'd120, 10'd240, 10'd240);

	// double yellow centre lines
	// each pair 5 wide with the second stripe 11 further on
	assign line_at = in_rect(px, py, 10'd0, 10'd232, 10'd200, 10'd5)
		|| in_rect(px, py, 10'd0, 10'd243, 10'd200, 10'd5)
		|| in_rect(px, py, 10'd440, 10'd232, 10'd200, 10'd5)
		|| in_rect(px, py, 10'd440, 10'd243, 10'd200, 10'd5)
		|| in_rect(px, py, 10'd312, 10'd0, 10'd5, 10'd200)
		|| in_rect(px, py, 10'd323, 10'd0, 10'd5, 10'd200)
		|| in_rect(px, py, 10'd312, 10'd360, 10'd5, 10'd200)
		|| in_rect(px, py, 10'd323, 10'd360, 10'd5, 10'd200);

	// east-west road band and north-south road band
	assign road_at = in_rect(px, py, 10'd0, 10'd120, `SCR_W, 10'd240)
		|| in_rect(px, py, 10'd200, 10'd0, 10'd240, `SCR_H);

	always_comb
	begin
		if (centre_at)
			bg_color.word = `COL_BLACK;
		else if (line_at)
			bg_color.word = `COL_YELLOW;
		else if (road_at)
			bg_color.word = `COL_BLACK;
		else
			bg_color.word = `COL_GREEN;
	end

endmodule

`default_nettype wire

// ==== scene/car_painter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module car_painter import vga_pkg::*, traffic_pkg::*; (
	input  coord_t  px,
	input  coord_t  py,
	input  offset_t off [8],
	output logic    car_hit,
	output color_t  car_color
);

	// ------------------------------------------------------------------
	// slot table
	// ------------------------------------------------------------------
	localparam dir_t slot_dir [8] = '{north, north, east, east, south, south, west, west};
	// lane position across travel
	localparam coord_t slot_base [8] = '{10'd275, 10'd215, 10'd315, 10'd255,
		10'd275, 10'd215, 10'd315, 10'd255};
	localparam logic [7:0] slot_col [8] = '{`COL_WHITE, `COL_GREEN, `COL_BLUE, `COL_CYAN,
		`COL_YELLOW, `COL_GREEN, `COL_MAGENTA, `COL_RED};

	// footprint of one car
	// north and west lanes mirror the south and east ones
	function automatic logic car_at(dir_t d, coord_t base, offset_t o, coord_t x, coord_t y);
		coord_t x0;
		coord_t y0;
		coord_t w;
		coord_t h;
		begin
			case (d)
				north:
				begin
					x0 = `SCR_W - base - `CAR_WID;
					y0 = `SCR_H - o - `CAR_LEN;
					w = `CAR_WID;
					h = `CAR_LEN;
				end
				east:
				begin
					x0 = o;
					y0 = base;
					w = `CAR_LEN;
					h = `CAR_WID;
				end
				south:
				begin
					x0 = base;
					y0 = o;
					w = `CAR_WID;
					h = `CAR_LEN;
				end
				default:
				begin
					// west
					x0 = `SCR_W - o - `CAR_LEN;
					y0 = `SCR_H - base - `CAR_WID;
					w = `CAR_LEN;
					h = `CAR_WID;
				end
			endcase
			// a wrapped origin lands above 640 or 480 and shows nothing
			car_at = in_rect(x, y, x0, y0, w, h);
		end
	endfunction

	// scan high to low so the lowest slot is written last
	always_comb
	begin
		car_hit = 1'b0;
		car_color.word = `COL_BLACK;
		for (int i = 7; i >= 0; i--)
		begin
			if (car_at(slot_dir[i], slot_base[i], off[i], px, py))
			begin
				car_hit = 1'b1;
				car_color.word = slot_col[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== traffic/lane_mover.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module lane_mover import traffic_pkg::*; #(
	parameter int SPEED    = 1,
	parameter bit VERTICAL = 1'b1
) (
	input  logic    dclk,
	input  logic    clr,
	input  logic    tick,
	input  logic    go,
	input  logic    lamp_green,
	output offset_t off,
	output logic    crossed
);

	// stop line and crossing point for this road
	localparam offset_t stop_off = VERTICAL ? `STOP_V : `STOP_H;
	localparam offset_t cross_off = VERTICAL ? `CROSS_V : `CROSS_H;
	localparam offset_t step = offset_t'(SPEED);

	offset_t next_off;
	logic    hold;
	logic    advance;

	// wraps at 1024
	assign next_off = off + step;

	// waiting only at the exact stop offset
	assign hold = !lamp_green && (off == stop_off);
	assign advance = tick && go && !hold;

	// counted on the same edge that moves the car onto the crossing point
	assign crossed = advance && (next_off == cross_off);

	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
			off <= '0;
		else if (advance)
			off <= next_off;
	end

endmodule

`default_nettype wire

// ==== traffic/traffic_sim.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module traffic_sim import traffic_pkg::*; (
	input  logic       dclk,
	input  logic       clr,
	input  logic       animate,
	input  logic [3:0] light,
	output offset_t    off [8],
	output logic [9:0] score,
	output logic       game_won
);

	logic       anim_s1;
	logic       anim_s2;
	logic       anim_d;
	logic       tick;
	logic       go;
	logic [7:0] crossed;
	logic [3:0] n_cross;

	// ------------------------------------------------------------------
	// animate request
	// ------------------------------------------------------------------
	// two flops into dclk then a registered rising edge detect
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			anim_s1 <= 1'b0;
			anim_s2 <= 1'b0;
			anim_d <= 1'b0;
			tick <= 1'b0;
		end
		else
		begin
			anim_s1 <= animate;
			anim_s2 <= anim_s1;
			anim_d <= anim_s2;
			tick <= anim_s2 && !anim_d;
		end
	end

	// traffic freezes once won
	assign go = !game_won;

	// even slots crawl and odd slots run double speed
	// pair i/2 follows light bit i/2
	for (genvar i = 0; i < 8; i++)
	begin : g_lane
		lane_mover #(
			.SPEED    (i % 2 + 1),
			.VERTICAL (((i / 2) % 2) == 0)
		) u_lane (
			.dclk       (dclk),
			.clr        (clr),
			.tick       (tick),
			.go         (go),
			.lamp_green (light[i / 2]),
			.off        (off[i]),
			.crossed    (crossed[i])
		);
	end

	// how many cars crossed on this tick
	always_comb
	begin
		n_cross = '0;
		for (int k = 0; k < 8; k++)
			n_cross = n_cross + {3'd0, crossed[k]};
	end

	// ------------------------------------------------------------------
	// score and win
	// ------------------------------------------------------------------
	always_ff @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			score <= '0;
			game_won <= 1'b0;
		end
		else
		begin
			score <= score + {6'd0, n_cross};
			// sticky until reset
			if (score >= `WIN_SCORE)
				game_won <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/intersection_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module intersection_top import vga_pkg::*, traffic_pkg::*; (
	input  logic       dclk,
	input  logic       clr,
	input  logic       animate,
	input  logic [3:0] light,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue,
	output logic [9:0] score,
	output logic       game_won
);

	// raster
	coord_t  px;
	coord_t  py;
	logic    active;
	logic    hsync_raw;
	logic    vsync_raw;
	// layers
	logic    top_hit;
	color_t  top_color;
	color_t  bg_color;
	logic    car_hit;
	color_t  car_color;
	// car positions
	offset_t off [8];

	// raw counters stay inside the timing block
	vga_timing u_timing (
		.dclk      (dclk),
		.clr       (clr),
		.hc        (),
		.vc        (),
		.px        (px),
		.py        (py),
		.active    (active),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	road_painter u_road (
		.px        (px),
		.py        (py),
		.light     (light),
		.top_hit   (top_hit),
		.top_color (top_color),
		.bg_color  (bg_color)
	);

	car_painter u_cars (
		.px        (px),
		.py        (py),
		.off       (off),
		.car_hit   (car_hit),
		.car_color (car_color)
	);

	traffic_sim u_sim (
		.dclk     (dclk),
		.clr      (clr),
		.animate  (animate),
		.light    (light),
		.off      (off),
		.score    (score),
		.game_won (game_won)
	);

	pixel_out u_pixel (
		.dclk      (dclk),
		.clr       (clr),
		.active    (active),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.top_hit   (top_hit),
		.top_color (top_color),
		.car_hit   (car_hit),
		.car_color (car_color),
		.bg_color  (bg_color),
		.hsync     (hsync),
		.vsync     (vsync),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

`default_nettype wire

// ==== verif/intersection_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "traffic_params.svh"

module intersection_tb;

	// 100 ns clock
	localparam int half_period = 50;
	localparam int frame_cycles = int'(`H_TOTAL) * int'(`V_TOTAL);
	// a dozen frames plus a few lines of slack
	localparam int max_cycles = 12 * frame_cycles + 8 * int'(`H_TOTAL);

	// lamp corners
	// index is the light bit
	localparam int red_lx [4] = '{363, 615, 262, 5};
	localparam int red_ly [4] = '{5, 283, 460, 182};
	localparam int green_lx [4] = '{382, 615, 243, 5};
	localparam int green_ly [4] = '{5, 302, 460, 163};
	// car colour per slot
	localparam int car_cols [8] = '{`COL_WHITE, `COL_GREEN, `COL_BLUE, `COL_CYAN,
		`COL_YELLOW, `COL_GREEN, `COL_MAGENTA, `COL_RED};

	logic        dclk;
	logic        clr;
	logic        animate;
	logic [3:0]  light;
	logic        hsync;
	logic        vsync;
	logic [2:0]  red;
	logic [2:0]  green;
	logic [1:0]  blue;
	logic [9:0]  score;
	logic        game_won;

	// model raster, cars and score
	logic [9:0]  m_hc;
	logic [9:0]  m_vc;
	int          m_off [8];
	int          score_m;
	logic [9:0]  exp_pix;
	logic        exp_valid = 1'b0;
	// bookkeeping
	int          checks = 0;
	int          errors = 0;
	int          other_errors = 0;
	int          cycles = 0;
	logic [31:0] rng;
	string       test_name;

	intersection_top uut (
		.dclk     (dclk),
		.clr      (clr),
		.animate  (animate),
		.light    (light),
		.hsync    (hsync),
		.vsync    (vsync),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.score    (score),
		.game_won (game_won)
	);

	initial
	begin
		dclk = 1'b0;
		forever
			#half_period dclk = ~dclk;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic check(input string what, input int exp_v, input int act_v);
		checks++;
		if (exp_v !== act_v)
		begin
			errors++;
			if (errors <= 50)
				$display("[ERROR] %s %s: expected %0h, actual %0h at %0t",
					test_name, what, exp_v, act_v, $time);
			if (errors == 50)
				$display("more mismatches are counted but not shown");
		end
	endtask

	function automatic bit in_box(int x, int y, int x0, int y0, int w, int h);
		return (x >= x0) && (x < x0 + w) && (y >= y0) && (y < y0 + h);
	endfunction

	// north and south travel vertically
	function automatic int stop_for(int d);
		return (d % 2 == 0) ? int'(`STOP_V) : int'(`STOP_H);
	endfunction

	function automatic int cross_for(int d);
		return (d % 2 == 0) ? int'(`CROSS_V) : int'(`CROSS_H);
	endfunction

	// ----------------------------------------------------------------------
	// reference picture
	// ----------------------------------------------------------------------
	// lamps and housings
	// -1 where nothing is drawn
	function automatic int top_layer(int x, int y, logic [3:0] lt);
		int col;
		col = -1;
		if (in_box(x, y, 0, 160, 25, 40) || in_box(x, y, 610, 280, 25, 40)
			|| in_box(x, y, 360, 0, 40, 25) || in_box(x, y, 240, 455, 40, 25))
			col = int'(`COL_YELLOW);
		// lamps cover their housings
		for (int i = 0; i < 4; i++)
		begin
			if (in_box(x, y, red_lx[i], red_ly[i], 15, 15))
				col = lt[i] ? int'(`COL_BLACK) : int'(`COL_RED);
			if (in_box(x, y, green_lx[i], green_ly[i], 15, 15))
				col = lt[i] ? int'(`COL_GREEN) : int'(`COL_BLACK);
		end
		return col;
	endfunction

	function automatic int car_layer(int x, int y);
		int res;
		int o;
		int base;
		int x0;
		int y0;
		int w;
		int h;
		res = -1;
		// high slots first so slot 0 ends on top
		for (int i = 7; i >= 0; i--)
		begin
			o = m_off[i];
			if ((i / 2) % 2 == 0)
				base = (i % 2 == 0) ? 275 : 215;
			else
				base = (i % 2 == 0) ? 315 : 255;
			w = ((i / 2) % 2 == 0) ? 30 : 60;
			h = ((i / 2) % 2 == 0) ? 60 : 30;
			case (i / 2)
				0:
				begin
					x0 = 640 - base - 30;
					y0 = (480 - o - 60) & 1023;
				end
				1:
				begin
					x0 = o;
					y0 = base;
				end
				2:
				begin
					x0 = base;
					y0 = o;
				end
				default:
				begin
					x0 = (640 - o - 60) & 1023;
					y0 = 480 - base - 30;
				end
			endcase
			if (in_box(x, y, x0, y0, w, h))
				res = car_cols[i];
		end
		return res;
	endfunction

	function automatic int background(int x, int y);
		int col;
		if (in_box(x, y, 200, 120, 240, 240))
			col = int'(`COL_BLACK);
		// two stripes per road arm
		else if (in_box(x, y, 0, 232, 200, 5) || in_box(x, y, 0, 243, 200, 5)
			|| in_box(x, y, 440, 232, 200, 5) || in_box(x, y, 440, 243, 200, 5)
			|| in_box(x, y, 312, 0, 5, 200) || in_box(x, y, 323, 0, 5, 200)
			|| in_box(x, y, 312, 360, 5, 200) || in_box(x, y, 323, 360, 5, 200))
			col = int'(`COL_YELLOW);
		else if ((y >= 120 && y < 360) || (x >= 200 && x < 440))
			col = int'(`COL_BLACK);
		else
			col = int'(`COL_GREEN);
		return col;
	endfunction

	// {hsync, vsync, rrrgggbb} for one counter state
	function automatic logic [9:0] expect_pixel(int hc, int vc, logic [3:0] lt);
		int col;
		logic hs;
		logic vs;
		hs = (hc >= int'(`H_PULSE));
		vs = (vc >= int'(`V_PULSE));
		if (hc < int'(`H_BP) || hc >= int'(`H_FP) || vc < int'(`V_BP) || vc >= int'(`V_FP))
			col = int'(`COL_BLACK);
		else
		begin
			col = top_layer(hc - int'(`H_BP), vc - int'(`V_BP), lt);
			if (col < 0)
				col = car_layer(hc - int'(`H_BP), vc - int'(`V_BP));
			if (col < 0)
				col = background(hc - int'(`H_BP), vc - int'(`V_BP));
		end
		return {hs, vs, col[7:0]};
	endfunction

	// ----------------------------------------------------------------------
	// model of the traffic
	// ----------------------------------------------------------------------
	task automatic step_model();
		int gain;
		gain = 0;
		// nothing moves once won
		if (score_m < int'(`WIN_SCORE))
		begin
			for (int i = 0; i < 8; i++)
			begin
				if (light[i / 2] || m_off[i] != stop_for(i / 2))
				begin
					m_off[i] = (m_off[i] + i % 2 + 1) % 1024;
					if (m_off[i] == cross_for(i / 2))
						gain++;
				end
			end
		end
		score_m = score_m + gain;
	endtask

	// one animate pulse inside vertical blanking
	task automatic send_tick();
		// not on the last line before the picture
		while (!(m_vc >= `V_FP || m_vc < `V_BP - 10'd1))
			@(negedge dclk);
		animate = 1'b1;
		repeat (2)
			@(negedge dclk);
		animate = 1'b0;
		// synchroniser, edge detect and offset update are done by now
		repeat (4)
			@(negedge dclk);
		step_model();
		check("score", score_m, int'(score));
		check("game_won", int'(score_m >= int'(`WIN_SCORE)), int'(game_won));
	endtask

	// returns at the first line of vertical blanking
	task automatic wait_vblank();
		@(negedge dclk);
		while (!(m_vc == `V_FP && m_hc == 10'd0))
			@(negedge dclk);
	endtask

	// ----------------------------------------------------------------------
	// raster counters and comparator
	// ----------------------------------------------------------------------
	always @(posedge dclk or posedge clr)
	begin
		if (clr)
		begin
			m_hc <= '0;
			m_vc <= '0;
		end
		else if (m_hc == `H_TOTAL - 10'd1)
		begin
			m_hc <= '0;
			m_vc <= (m_vc == `V_TOTAL - 10'd1) ? 10'd0 : m_vc + 10'd1;
		end
		else
			m_hc <= m_hc + 10'd1;
	end

	// what the output register takes at this edge
	always @(posedge dclk)
	begin
		if (clr)
			exp_valid = 1'b0;
		else
		begin
			exp_pix = expect_pixel(int'(m_hc), int'(m_vc), light);
			exp_valid = 1'b1;
		end
	end

	// outputs are settled mid cycle
	always @(negedge dclk)
	begin
		if (exp_valid)
		begin
			check("hsync", int'(exp_pix[9]), int'(hsync));
			check("vsync", int'(exp_pix[8]), int'(vsync));
			check("colour", int'(exp_pix[7:0]), int'({red, green, blue}));
		end
	end

	always @(posedge dclk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: the tests did not end within %0d cycles", max_cycles);
			$display("checks %0d, value errors %0d, other errors %0d",
				checks, errors, other_errors);
			$display("Something failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial
	begin
		int n;
		int red_dir;
		int guard;
		int frozen_score;
		clr = 1'b1;
		animate = 1'b0;
		light = 4'h0;
		rng = 32'd62913;
		score_m = 0;
		for (int i = 0; i < 8; i++)
			m_off[i] = 0;
		test_name = "reset";
		repeat (2)
			@(posedge dclk);
		@(negedge dclk);
		check("hsync", 1, int'(hsync));
		check("vsync", 1, int'(vsync));
		check("colour", 0, int'({red, green, blue}));
		check("score", 0, int'(score));
		check("game_won", 0, int'(game_won));
		clr = 1'b0;

		// random lights held for a frame each
		test_name = "static scene";
		for (int f = 0; f < 2; f++)
		begin
			rng = xorshift(rng);
			light = rng[3:0];
			wait_vblank();
		end

		test_name = "movement";
		light = 4'hf;
		rng = xorshift(rng);
		n = 1 + int'(rng[5:0]);
		repeat (n)
			send_tick();
		wait_vblank();

		// one approach red until both its cars wait
		test_name = "stop at red";
		rng = xorshift(rng);
		red_dir = int'(rng[1:0]);
		light = 4'hf & ~(4'h1 << red_dir);
		guard = 0;
		while (guard < 1100 && !(m_off[2 * red_dir] == stop_for(red_dir)
			&& m_off[2 * red_dir + 1] == stop_for(red_dir)))
		begin
			send_tick();
			guard++;
		end
		if (guard >= 1100)
		begin
			other_errors++;
			$display("stop at red: the cars of approach %0d never reached the stop line",
				red_dir);
		end
		repeat (8)
			send_tick();
		wait_vblank();

		test_name = "resume";
		light = 4'hf;
		repeat (8)
			send_tick();
		wait_vblank();

		test_name = "score and win";
		guard = 0;
		while (score_m < int'(`WIN_SCORE) && guard < 4096)
		begin
			send_tick();
			guard++;
		end
		if (score_m < int'(`WIN_SCORE))
		begin
			other_errors++;
			$display("score and win: the score never reached the win limit");
		end
		check("game_won", 1, int'(game_won));

		// traffic stays frozen after the win
		test_name = "frozen";
		frozen_score = score_m;
		repeat (8)
			send_tick();
		check("score", frozen_score, int'(score));
		wait_vblank();

		$display("checks %0d, value errors %0d, other errors %0d",
			checks, errors, other_errors);
		if (errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/vga_pkg.sv
common/traffic_pkg.sv
video/vga_timing.sv
video/pixel_out.sv
scene/road_painter.sv
scene/car_painter.sv
traffic/lane_mover.sv
traffic/traffic_sim.sv
source/intersection_top.sv
verif/intersection_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f compile.f --top-module intersection_tb \
	&& ./obj_dir/Vintersection_tb | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
